/* sim/battleship_stim.txt */
# Columns: player horizontal(1) or vertical(0) row col expected_kind
# Kinds: 0 placed, 1 rejected, 2 miss, 3 hit, 4 win; comment names the next player to move
# Player 0 fleet, lengths 5 4 3 3 2
1 1 0 0 1    # next p0, wrong player
0 1 0 0 0    # next p0, ship 5 along row 0
0 1 5 7 1    # next p0, ship 4 off the right edge
0 0 7 9 1    # next p0, ship 4 off the bottom edge
0 0 0 2 1    # next p0, ship 4 crosses ship 5
0 0 6 9 0    # next p0, ship 4 in the corner
0 1 10 0 1   # next p0, row off board
0 1 6 7 1    # next p0, last cell lands on ship 4
0 1 2 7 0    # next p0, ship 3 on the right edge
0 0 4 0 0    # next p0, ship 3 on the left edge
0 1 9 0 0    # next p1, ship 2 on the bottom edge
0 1 5 5 1    # next p1, fleet already placed
# Player 1 fleet
1 0 0 0 0    # next p1
1 1 9 6 0    # next p1
1 0 2 5 0    # next p1
1 1 4 0 1    # next p1, overlaps ship 5
1 1 7 1 0    # next p1
1 0 0 8 0    # next p0, shooting starts
# Shooting
1 0 5 5 1    # next p0, out of turn
0 0 5 5 2    # next p1
1 0 0 0 3    # next p0
0 0 0 0 3    # next p1
1 0 5 5 2    # next p0
0 0 5 5 1    # next p0, repeat on a miss
0 0 0 0 1    # next p0, repeat on a hit
0 0 10 3 1   # next p0, row off board
0 0 3 12 1   # next p0, col off board
0 0 1 0 3    # next p1
1 0 0 0 1    # next p1, repeat on its own hit
1 0 1 1 2    # next p0
0 0 2 0 3    # next p1
1 0 0 1 3    # next p0
0 0 3 0 3    # next p1
1 0 3 3 2    # next p0
0 0 4 0 3    # next p1
1 0 6 9 3    # next p0
0 0 9 6 3    # next p1
1 0 7 7 2    # next p0
0 0 9 7 3    # next p1
1 0 8 8 2    # next p0
0 0 9 8 3    # next p1
1 0 4 4 2    # next p0
0 0 9 9 3    # next p1
1 0 2 7 3    # next p0
0 0 2 5 3    # next p1
1 0 5 1 2    # next p0
0 0 3 5 3    # next p1
1 0 6 6 2    # next p0
0 0 4 5 3    # next p1
1 0 3 8 2    # next p0
0 0 7 1 3    # next p1
1 0 9 0 3    # next p0
0 0 7 2 3    # next p1
1 0 8 2 2    # next p0
0 0 7 3 3    # next p1
1 0 1 7 2    # next p0
0 0 0 8 3    # next p1
1 0 7 5 2    # next p0
0 0 1 8 4    # game over, 17th hit
0 0 6 6 1    # game over
1 0 6 6 1    # game over

/* tb.f */
common/battleship_pkg.sv
board/board_mem.sv
hw/cell_walker.sv
hw/fleet_tracker.sv
hw/game_ctrl.sv
hw/battleship_top.sv
sim/tb_battleship_asserts.sv
sim/tb_battleship.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_battleship
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_battleship.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_battleship;
    import battleship_pkg::*;

    localparam int    READY_TIMEOUT = 200;                        // Cycles allowed per report
    localparam string STIM_FILE     = "sim/battleship_stim.txt";

    logic     clk;
    logic     reset;
    logic     read;
    request_t req;
    report_t  data_out;
    logic     data_ready;

    int request_count;
    int mismatch_count;
    int timeout_count;
    int file_errors;      // Missing or empty stimulus file

    battleship_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .read       (read),
        .req        (req),
        .data_out   (data_out),
        .data_ready (data_ready)
    );

    always #5 clk = ~clk;                                          // 10 ns period

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic check_report(input report_t expected, input report_t actual);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("error at %0t ns: report mismatch, expected kind %0d row %0d col %0d player %0d",
                     $time, expected.kind, expected.row, expected.col, expected.player);
            $display("    got kind %0d row %0d col %0d player %0d",
                     actual.kind, actual.row, actual.col, actual.player);
        end
    endtask

    // ----------------------------------------------------------------------
    // Request driving
    // ----------------------------------------------------------------------
    task automatic send_request(input request_t r);
        @(posedge clk);
        req  <= r;
        read <= 1'b1;                                              // One-cycle strobe
        @(posedge clk);
        read <= 1'b0;
    endtask

    // Sample on the falling edge, data_ready is settled there
    task automatic wait_for_report(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < READY_TIMEOUT)
        begin
            @(negedge clk);
            if (data_ready)
                seen = 1'b1;
            cycles++;
        end
    endtask

    // One line of the file, request out and report back
    task automatic run_request(input int player, input int horiz, input int row, input int col,
                               input int kind, output logic ok);
        request_t r;
        report_t  expected;
        logic     seen;
        r        = '{player: 1'(player), horizontal: 1'(horiz),
                     row: coord_t'(row), col: coord_t'(col)};
        // Report echoes the request, only the kind comes from the file
        expected = '{kind: report_kind_t'(kind), row: coord_t'(row),
                     col: coord_t'(col), player: 1'(player)};
        send_request(r);
        wait_for_report(seen);
        request_count++;
        ok = seen;
        if (seen)
            check_report(expected, data_out);
        else
        begin
            $display("Timed out after %0d cycles waiting for data_ready on request %0d",
                     READY_TIMEOUT, request_count);
            timeout_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin
        int    fd;
        string line;
        int    player, horiz, row, col, kind;
        logic  running;
        logic  ok;
        int    assert_count;    // Failures seen by the bound checker

        clk            = 1'b0;
        reset          = 1'b1;
        read           = 1'b0;
        req            = '0;
        request_count  = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        file_errors    = 0;

        repeat (8) @(posedge clk);                                 // Reset for 8 cycles
        reset <= 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            file_errors++;
        end
        else
        begin
            running = 1'b1;
            while (running)
            begin
                if ($fgets(line, fd) == 0)
                    running = 1'b0;                                // End of file
                else if ($sscanf(line, "%d %d %d %d %d", player, horiz, row, col, kind) == 5)
                begin
                    run_request(player, horiz, row, col, kind, ok);
                    running = ok;                                  // Stuck DUT ends the run
                end
                // Comment and blank lines fall through
            end
            $fclose(fd);
            if (request_count == 0)
            begin
                $display("No requests were found in %s", STIM_FILE);
                file_errors++;
            end
        end

        assert_count = dut_i.asserts_i.assert_failures;
        $display("Requests %0d, mismatches %0d, timeouts %0d, file errors %0d, assertions %0d",
                 request_count, mismatch_count, timeout_count, file_errors, assert_count);
        if (mismatch_count + timeout_count + file_errors + assert_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_battleship_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_battleship_asserts #(
    parameter int BOARD_ROWS = battleship_pkg::BOARD_ROWS,
    parameter int BOARD_COLS = battleship_pkg::BOARD_COLS
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    data_ready,
    input battleship_pkg::report_t data_out,
    input logic                    we0,
    input logic                    we1
);
    import battleship_pkg::*;

    logic shot_report;          // Report that names a target cell
    int   assert_failures = 0;  // Failed assertions so far

    assign shot_report = data_out.kind inside {rk_miss, rk_hit, rk_win};

    // Report strobe is a single pulse
    ready_single_cycle: assert property (@(posedge clk) disable iff (reset)
        data_ready |=> !data_ready)
        else
        begin
            assert_failures++;
            $error("data_ready stayed high for two cycles");
        end

    // Cleared by reset, and quiet while it lasts
    ready_low_in_reset: assert property (@(posedge clk) reset |=> !data_ready)
        else
        begin
            assert_failures++;
            $error("data_ready high during reset");
        end

    // Board writes are over before the report goes out
    write_before_report: assert property (@(posedge clk) disable iff (reset)
        data_ready |-> !(we0 || we1))
        else
        begin
            assert_failures++;
            $error("board write while a report goes out");
        end

    shot_on_board: assert property (@(posedge clk) disable iff (reset)
        (data_ready && shot_report)
            |-> (int'(data_out.row) < BOARD_ROWS) && (int'(data_out.col) < BOARD_COLS))
        else
        begin
            assert_failures++;
            $error("shot report outside the board");
        end

endmodule

bind battleship_top tb_battleship_asserts #(
    .BOARD_ROWS (BOARD_ROWS),
    .BOARD_COLS (BOARD_COLS)
) asserts_i (
    .clk        (clk),
    .reset      (reset),
    .data_ready (data_ready),
    .data_out   (data_out),
    .we0        (we0),
    .we1        (we1)
);

`default_nettype wire

/* hw/battleship_top.sv */
`timescale 1ns/1ps
`default_nettype none

module battleship_top #(
    parameter int BOARD_ROWS = battleship_pkg::BOARD_ROWS,
    parameter int BOARD_COLS = battleship_pkg::BOARD_COLS
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read,         // One-cycle request strobe
    input  battleship_pkg::request_t  req,
    output battleship_pkg::report_t   data_out,
    output logic                      data_ready    // One-cycle pulse per report
);
    import battleship_pkg::*;

    // Walker cursor, shared by both boards
    coord_t    cur_row, cur_col;
    logic      walk_last;
    logic      walk_start, walk_horizontal;
    coord_t    walk_row, walk_col;
    ship_len_t walk_len;

    // Board ports
    logic      we0, we1;
    cell_t     cell_wr;
    cell_t     cell_rd0, cell_rd1;

    // Fleet tracker
    ship_len_t next_len;
    logic      fleet_placed, final_hit;
    logic      place_done, hit_done, track_player;

    game_ctrl #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .read            (read),
        .req             (req),
        .cell_rd0        (cell_rd0),
        .cell_rd1        (cell_rd1),
        .cur_row         (cur_row),
        .cur_col         (cur_col),
        .walk_last       (walk_last),
        .next_len        (next_len),
        .fleet_placed    (fleet_placed),
        .final_hit       (final_hit),
        .walk_start      (walk_start),
        .walk_row        (walk_row),
        .walk_col        (walk_col),
        .walk_horizontal (walk_horizontal),
        .walk_len        (walk_len),
        .we0             (we0),
        .we1             (we1),
        .cell_wr         (cell_wr),
        .place_done      (place_done),
        .hit_done        (hit_done),
        .track_player    (track_player),
        .data_out        (data_out),
        .data_ready      (data_ready)
    );

    cell_walker #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) walker_i (
        .clk             (clk),
        .reset           (reset),
        .walk_start      (walk_start),
        .walk_row        (walk_row),
        .walk_col        (walk_col),
        .walk_horizontal (walk_horizontal),
        .walk_len        (walk_len),
        .cur_row         (cur_row),
        .cur_col         (cur_col),
        .walk_last       (walk_last)
    );

    fleet_tracker tracker_i (
        .clk          (clk),
        .reset        (reset),
        .track_player (track_player),
        .place_done   (place_done),
        .hit_done     (hit_done),
        .next_len     (next_len),
        .fleet_placed (fleet_placed),
        .final_hit    (final_hit)
    );

    // Player 0 board
    board_mem #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) board0_i (
        .clk     (clk),
        .reset   (reset),
        .we      (we0),
        .row     (cur_row),
        .col     (cur_col),
        .cell_wr (cell_wr),
        .cell_rd (cell_rd0)
    );

    // Player 1 board
    board_mem #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) board1_i (
        .clk     (clk),
        .reset   (reset),
        .we      (we1),
        .row     (cur_row),
        .col     (cur_col),
        .cell_wr (cell_wr),
        .cell_rd (cell_rd1)
    );

endmodule

`default_nettype wire

/* hw/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module game_ctrl #(
    parameter int BOARD_ROWS = battleship_pkg::BOARD_ROWS,
    parameter int BOARD_COLS = battleship_pkg::BOARD_COLS
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read,
    input  battleship_pkg::request_t  req,
    input  battleship_pkg::cell_t     cell_rd0,
    input  battleship_pkg::cell_t     cell_rd1,
    input  battleship_pkg::coord_t    cur_row,
    input  battleship_pkg::coord_t    cur_col,
    input  logic                      walk_last,
    input  battleship_pkg::ship_len_t next_len,
    input  logic                      fleet_placed,
    input  logic                      final_hit,
    output logic                      walk_start,
    output battleship_pkg::coord_t    walk_row,
    output battleship_pkg::coord_t    walk_col,
    output logic                      walk_horizontal,
    output battleship_pkg::ship_len_t walk_len,
    output logic                      we0,
    output logic                      we1,
    output battleship_pkg::cell_t     cell_wr,
    output logic                      place_done,
    output logic                      hit_done,
    output logic                      track_player,
    output battleship_pkg::report_t   data_out,
    output logic                      data_ready
);
    import battleship_pkg::*;

    typedef enum logic [2:0] {
        st_idle,    // Wait for read
        st_check,   // Player and bounds check
        st_scan,    // First walk, look for collisions
        st_write,   // Second walk, mark the ship
        st_done,    // Tracker updated, report placement
        st_shot     // Resolve miss or hit
    } state_t;

    typedef enum logic [1:0] {ph_place, ph_shoot, ph_over} phase_t;

    state_t       state, next_state;
    phase_t       phase;
    logic         expected;         // Player whose turn it is
    request_t     req_q;            // Request under way
    logic         req_ok;
    logic         fits;
    logic         wr_en;
    cell_t        cell_rd;
    logic         rep_en;
    report_kind_t rep_kind;
    coord_t       rep_row, rep_col;

    // ----------------------------------------------------------------------
    // Board and tracker steering
    // ----------------------------------------------------------------------
    // Placement works on the player's own board, a shot on the opponent's
    assign track_player    = (phase == ph_place) ? req_q.player : ~req_q.player;
    assign cell_rd         = track_player ? cell_rd1 : cell_rd0;
    assign we0             = wr_en && !track_player;
    assign we1             = wr_en && track_player;
    assign walk_row        = req_q.row;
    assign walk_col        = req_q.col;
    assign walk_horizontal = req_q.horizontal;
    assign walk_len        = (phase == ph_place) ? next_len : ship_len_t'(1);  // Shot is one cell

    // Request checks, only here
    always_comb
    begin
        fits = 1'b0;
        case (phase)
            ph_place:
                if (req_q.horizontal)
                    fits = (int'(req_q.row) < BOARD_ROWS)
                        && (int'(req_q.col) + int'(next_len) <= BOARD_COLS);
                else
                    fits = (int'(req_q.col) < BOARD_COLS)
                        && (int'(req_q.row) + int'(next_len) <= BOARD_ROWS);
            ph_shoot:
                fits = (int'(req_q.row) < BOARD_ROWS) && (int'(req_q.col) < BOARD_COLS);
            default:
                fits = 1'b0;                // Game over, nothing is legal
        endcase
        req_ok = fits && (req_q.player == expected);
    end

    // ----------------------------------------------------------------------
    // FSM next state and strobes
    // ----------------------------------------------------------------------
    always_comb
    begin
        next_state = state;
        walk_start = 1'b0;
        wr_en      = 1'b0;
        cell_wr    = cell_empty;
        place_done = 1'b0;
        hit_done   = 1'b0;
        rep_en     = 1'b0;
        rep_kind   = rk_rejected;           // Default outcome
        rep_row    = req_q.row;
        rep_col    = req_q.col;
        case (state)
            st_idle:
                if (read)
                    next_state = st_check;
            st_check:
                if (req_ok)
                begin
                    walk_start = 1'b1;
                    next_state = (phase == ph_place) ? st_scan : st_shot;
                end
                else
                begin
                    rep_en     = 1'b1;      // Wrong player, off board or game over
                    next_state = st_idle;
                end
            st_scan:
                if (cell_rd != cell_empty)
                begin
                    rep_en     = 1'b1;      // Overlap, give up at once
                    next_state = st_idle;
                end
                else if (walk_last)
                begin
                    walk_start = 1'b1;      // All clear, walk again to write
                    next_state = st_write;
                end
            st_write:
            begin
                wr_en   = 1'b1;
                cell_wr = cell_ship;
                if (walk_last)
                begin
                    place_done = 1'b1;
                    next_state = st_done;
                end
            end
            st_done:
            begin
                rep_en     = 1'b1;
                rep_kind   = rk_placed;
                next_state = st_idle;
            end
            st_shot:
            begin
                rep_en     = 1'b1;
                rep_row    = cur_row;       // Same cell as the request
                rep_col    = cur_col;
                next_state = st_idle;
                if (cell_rd == cell_empty)
                begin
                    wr_en    = 1'b1;
                    cell_wr  = cell_miss;
                    rep_kind = rk_miss;
                end
                else if (cell_rd == cell_ship)
                begin
                    wr_en    = 1'b1;
                    cell_wr  = cell_hit;
                    hit_done = 1'b1;
                    rep_kind = final_hit ? rk_win : rk_hit;
                end
                // Miss or hit cell already, repeat shot stays rejected
            end
            default:
                next_state = st_idle;
        endcase
    end

    // Request is taken only while idle
    always_ff @(posedge clk)
    begin
        if (state == st_idle && read)
            req_q <= req;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= st_idle;
            phase      <= ph_place;
            expected   <= 1'b0;             // Player 0 places first
            data_out   <= '0;
            data_ready <= 1'b0;
        end
        else
        begin
            state      <= next_state;
            data_ready <= rep_en;
            if (rep_en)
                data_out <= '{kind: rep_kind, row: rep_row, col: rep_col, player: req_q.player};
            // Fleet complete, hand over to player 1 or start shooting
            if (state == st_done && fleet_placed)
            begin
                if (req_q.player)
                begin
                    phase    <= ph_shoot;
                    expected <= 1'b0;       // Player 0 shoots first
                end
                else
                    expected <= 1'b1;
            end
            // Turn passes on every miss or hit
            if (state == st_shot && wr_en)
            begin
                expected <= ~expected;
                if (hit_done && final_hit)
                    phase <= ph_over;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fleet_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module fleet_tracker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      track_player,   // Placing player or target board
    input  logic                      place_done,
    input  logic                      hit_done,
    output battleship_pkg::ship_len_t next_len,
    output logic                      fleet_placed,
    output logic                      final_hit
);
    import battleship_pkg::*;

    ship_idx_t  ship_idx [2];   // Next ship per player
    hit_count_t hit_cnt  [2];   // Hits taken per board
    ship_idx_t  cur_idx;

    assign cur_idx      = ship_idx[track_player];
    assign fleet_placed = (cur_idx == ship_idx_t'(NUM_SHIPS));
    assign next_len     = fleet_placed ? '0 : SHIP_LENGTHS[cur_idx];
    // Next hit on this board sinks the last ship cell
    assign final_hit    = (hit_cnt[track_player] == hit_count_t'(FLEET_CELLS - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ship_idx <= '{default: '0};
            hit_cnt  <= '{default: '0};
        end
        else
        begin
            if (place_done && !fleet_placed)
                ship_idx[track_player] <= cur_idx + 1'b1;
            if (hit_done)
                hit_cnt[track_player] <= hit_cnt[track_player] + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/cell_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module cell_walker #(
    parameter int BOARD_ROWS = battleship_pkg::BOARD_ROWS,
    parameter int BOARD_COLS = battleship_pkg::BOARD_COLS
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      walk_start,
    input  battleship_pkg::coord_t    walk_row,
    input  battleship_pkg::coord_t    walk_col,
    input  logic                      walk_horizontal,
    input  battleship_pkg::ship_len_t walk_len,
    output battleship_pkg::coord_t    cur_row,
    output battleship_pkg::coord_t    cur_col,
    output logic                      walk_last
);
    import battleship_pkg::*;

    ship_len_t remain;      // Cells left after the current one
    logic      active;
    logic      horiz;       // Direction of the walk under way

    assign walk_last = active && (remain == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active  <= 1'b0;
            horiz   <= 1'b0;
            remain  <= '0;
            cur_row <= '0;
            cur_col <= '0;
        end
        else if (walk_start)
        begin
            // Origin shows up the cycle after the start pulse
            active  <= 1'b1;
            horiz   <= walk_horizontal;
            remain  <= walk_len - 1'b1;
            cur_row <= walk_row;
            cur_col <= walk_col;
        end
        else if (walk_last)
            active <= 1'b0;
        else if (active)
        begin
            remain <= remain - 1'b1;
            // Stop at the edge, the cursor never leaves the board
            if (horiz)
            begin
                if (int'(cur_col) < BOARD_COLS - 1)
                    cur_col <= cur_col + 1'b1;
            end
            else if (int'(cur_row) < BOARD_ROWS - 1)
                cur_row <= cur_row + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* board/board_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module board_mem #(
    parameter int BOARD_ROWS = battleship_pkg::BOARD_ROWS,
    parameter int BOARD_COLS = battleship_pkg::BOARD_COLS
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  battleship_pkg::coord_t row,
    input  battleship_pkg::coord_t col,
    input  battleship_pkg::cell_t  cell_wr,
    output battleship_pkg::cell_t  cell_rd
);
    import battleship_pkg::*;

    cell_t grid [BOARD_ROWS][BOARD_COLS];  // One cell state per square
    logic  on_grid;

    // Cursor can sit past the edge while idle, keep it off the array
    assign on_grid = (int'(row) < BOARD_ROWS) && (int'(col) < BOARD_COLS);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int r = 0; r < BOARD_ROWS; r++)
            begin
                for (int c = 0; c < BOARD_COLS; c++)
                begin
                    grid[r][c] <= cell_empty;  // New game, empty sea
                end
            end
        end
        else if (we && on_grid)
        begin
            grid[row][col] <= cell_wr;
        end
    end

    // Read is combinational so the controller sees the cell the walker points at
    assign cell_rd = on_grid ? grid[row][col] : cell_empty;

endmodule

`default_nettype wire

/* common/battleship_pkg.sv */
`default_nettype none

package battleship_pkg;

    // ----------------------------------------------------------------------
    // Board and fleet constants
    // ----------------------------------------------------------------------
    localparam int BOARD_ROWS  = 10;
    localparam int BOARD_COLS  = 10;
    localparam int NUM_SHIPS   = 5;
    localparam int FLEET_CELLS = 17;        // 5 + 4 + 3 + 3 + 2

    typedef logic [3:0] coord_t;            // Row or column index
    typedef logic [2:0] ship_len_t;         // Ship length, also walk step count
    typedef logic [2:0] ship_idx_t;         // Next ship to place
    typedef logic [4:0] hit_count_t;        // Hits taken by one board

    // Placement order, entry 0 goes first
    localparam ship_len_t [NUM_SHIPS-1:0] SHIP_LENGTHS = {3'd2, 3'd3, 3'd3, 3'd4, 3'd5};

    // Encoding kept from the LED board: off, blue, red, green
    typedef enum logic [1:0] {
        cell_empty = 2'b00,
        cell_miss  = 2'b01,
        cell_hit   = 2'b10,
        cell_ship  = 2'b11
    } cell_t;

    typedef enum logic [2:0] {
        rk_placed   = 3'd0,
        rk_rejected = 3'd1,
        rk_miss     = 3'd2,
        rk_hit      = 3'd3,
        rk_win      = 3'd4
    } report_kind_t;

    typedef struct packed {
        logic   player;
        logic   horizontal;                 // 1 walks along the row
        coord_t row;
        coord_t col;
    } request_t;

    typedef struct packed {
        report_kind_t kind;
        coord_t       row;
        coord_t       col;
        logic         player;               // Player who made the request
    } report_t;

endpackage

`default_nettype wire
